// File: hw/ifm_chunk_top.sv
`timescale 1ns/1ns
`include "ifm_consts.svh"

module ifm_chunk_top import ifm_pkg::*; (
	 input  logic      clk_i
	,input  logic      rst_i

	,input  logic      sm_wr_en_i
	,input  word_idx_t sm_wr_addr_i
	,input  map_word_t sm_wr_data_i

	,input  logic      nz_wr_en_i
	,input  mem_addr_t nz_wr_addr_i
	,input  data_t     nz_wr_data_i

	,input  logic      start_i
	,input  word_idx_t word_count_i
	,input  logic      credit_i

	,output logic      out_valid_o
	,output chan_idx_t out_index_o
	,output data_t     out_data_o

	,output logic      done_o
	,output logic      busy_o
);

	map_word_t  map_word_w;
	map_pos_t   match_pos_w;
	logic       chunk_start_w;
	logic       word_end_w;
	logic       issue_w;
	chan_idx_t  chan_idx_w;
	pos_count_t below_w [`IFM_MAP_W];
	pos_count_t total_w;
	mem_addr_t  rd_addr_w;

	logic       out_valid_r;
	chan_idx_t  out_index_r;

	sparsemap_scan u_scan (
		 .clk_i         (clk_i)
		,.rst_i         (rst_i)
		,.sm_wr_en_i    (sm_wr_en_i)
		,.sm_wr_addr_i  (sm_wr_addr_i)
		,.sm_wr_data_i  (sm_wr_data_i)
		,.start_i       (start_i)
		,.word_count_i  (word_count_i)
		,.credit_i      (credit_i)
		,.map_word_o    (map_word_w)
		,.match_pos_o   (match_pos_w)
		,.chunk_start_o (chunk_start_w)
		,.word_end_o    (word_end_w)
		,.issue_o       (issue_w)
		,.chan_idx_o    (chan_idx_w)
		,.busy_o        (busy_o)
		,.done_o        (done_o)
	);

	prefix_sum u_prefix_sum (
		 .map_i   (map_word_w)
		,.below_o (below_w)
		,.total_o (total_w)
	);

	ifm_input_sel u_input_sel (
		 .clk_i         (clk_i)
		,.rst_i         (rst_i)
		,.chunk_start_i (chunk_start_w)
		,.word_end_i    (word_end_w)
		,.match_pos_i   (match_pos_w)
		,.below_i       (below_w)
		,.total_i       (total_w)
		,.rd_addr_o     (rd_addr_w)
	);

	ifm_data_mem u_data_mem (
		 .clk_i        (clk_i)
		,.nz_wr_en_i   (nz_wr_en_i)
		,.nz_wr_addr_i (nz_wr_addr_i)
		,.nz_wr_data_i (nz_wr_data_i)
		,.rd_en_i      (issue_w)
		,.rd_addr_i    (rd_addr_w)
		,.rd_data_o    (out_data_o)
	);

	//////////////////////////////////////////////////////////////////////
	// Align valid and index with the registered memory read
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			out_valid_r <= 1'b0;
		end else begin
			out_valid_r <= issue_w;
		end
	end

	always_ff @(posedge clk_i) begin
		if (issue_w) begin
			out_index_r <= chan_idx_w;
		end
	end

	assign out_valid_o = out_valid_r;
	assign out_index_o = out_index_r;

endmodule

// File: hw/ifm_consts.svh
`ifndef IFM_CONSTS_SVH
`define IFM_CONSTS_SVH

// Channel bits per sparsemap word
`define IFM_MAP_W 8

// Sparsemap words held for one chunk
`define IFM_MAP_DEPTH 8

// Packed value entries, sized for a fully dense chunk
`define IFM_MEM_SIZE 64

// Activation value width
`define IFM_DATA_W 16

// Consumer slots granted after reset
`define IFM_CREDITS 4

`endif

// File: hw/ifm_data_mem.sv
`timescale 1ns/1ns
`include "ifm_consts.svh"

module ifm_data_mem import ifm_pkg::*; (
	 input  logic      clk_i

	,input  logic      nz_wr_en_i
	,input  mem_addr_t nz_wr_addr_i
	,input  data_t     nz_wr_data_i

	,input  logic      rd_en_i
	,input  mem_addr_t rd_addr_i
	,output data_t     rd_data_o
);

	localparam int ADDR_W = $clog2(`IFM_MEM_SIZE);

	data_t mem [`IFM_MEM_SIZE];

	// Addresses past the array are dropped on write
	always_ff @(posedge clk_i) begin
		if (nz_wr_en_i && !nz_wr_addr_i[ADDR_W]) begin
			mem[nz_wr_addr_i[ADDR_W-1:0]] <= nz_wr_data_i;
		end
	end

	// Registered read, zero beyond the array
	always_ff @(posedge clk_i) begin
		if (rd_en_i && rd_addr_i[ADDR_W]) begin
			rd_data_o <= '0;
		end else if (rd_en_i) begin
			rd_data_o <= mem[rd_addr_i[ADDR_W-1:0]];
		end
	end

endmodule

// File: hw/ifm_input_sel.sv
`timescale 1ns/1ns
`include "ifm_consts.svh"

module ifm_input_sel import ifm_pkg::*; (
	 input  logic       clk_i
	,input  logic       rst_i

	,input  logic       chunk_start_i
	,input  logic       word_end_i
	,input  map_pos_t   match_pos_i

	,input  pos_count_t below_i [`IFM_MAP_W]
	,input  pos_count_t total_i

	,output mem_addr_t  rd_addr_o
);

	// Packed address of the first nonzero of the current word
	mem_addr_t base_r;

	// Offset of the matched bit inside the current word
	pos_count_t offset_w;

	//////////////////////////////////////////////////////////////////////
	// Running base
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			base_r <= '0;
		end else if (chunk_start_i) begin
			base_r <= '0;
		end else if (word_end_i) begin
			// Skip past every nonzero of the word just finished
			base_r <= base_r + mem_addr_t'(total_i);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read address
	//////////////////////////////////////////////////////////////////////

	assign offset_w = below_i[match_pos_i];

	assign rd_addr_o = base_r + mem_addr_t'(offset_w);

endmodule

// File: hw/ifm_pkg.sv
`include "ifm_consts.svh"

package ifm_pkg;

	typedef logic [`IFM_MAP_W-1:0]             map_word_t;
	typedef logic [$clog2(`IFM_MAP_W)-1:0]     map_pos_t;
	typedef logic [$clog2(`IFM_MAP_W):0]       pos_count_t;
	typedef logic [$clog2(`IFM_MAP_DEPTH)-1:0] word_idx_t;
	typedef logic [$clog2(`IFM_MEM_SIZE):0]    mem_addr_t;

	// Channel index is {word index, bit position}
	typedef logic [$clog2(`IFM_MAP_DEPTH)+$clog2(`IFM_MAP_W)-1:0] chan_idx_t;

	typedef logic [`IFM_DATA_W-1:0]            data_t;
	typedef logic [$clog2(`IFM_CREDITS+1)-1:0] credit_t;

	typedef enum logic [1:0] {
		SCAN_IDLE,
		SCAN_FETCH,
		SCAN_EMIT,
		SCAN_DONE
	} scan_state_e;

endpackage

// File: hw/prefix_sum.sv
`timescale 1ns/1ns
`include "ifm_consts.svh"

module prefix_sum import ifm_pkg::*; (
	 input  map_word_t  map_i
	,output pos_count_t below_o [`IFM_MAP_W]
	,output pos_count_t total_o
);

	//////////////////////////////////////////////////////////////////////
	// Exclusive running count over the word
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		pos_count_t acc;
		acc = '0;
		for (int i = 0; i < `IFM_MAP_W; i++) begin
			// Ones strictly below position i
			below_o[i] = acc;
			acc = acc + pos_count_t'(map_i[i]);
		end
		// All ones in the word
		total_o = acc;
	end

endmodule

// File: hw/sparsemap_scan.sv
`timescale 1ns/1ns
`include "ifm_consts.svh"

module sparsemap_scan import ifm_pkg::*; (
	 input  logic      clk_i
	,input  logic      rst_i

	,input  logic      sm_wr_en_i
	,input  word_idx_t sm_wr_addr_i
	,input  map_word_t sm_wr_data_i

	,input  logic      start_i
	,input  word_idx_t word_count_i
	,input  logic      credit_i

	,output map_word_t map_word_o
	,output map_pos_t  match_pos_o
	,output logic      chunk_start_o
	,output logic      word_end_o
	,output logic      issue_o
	,output chan_idx_t chan_idx_o

	,output logic      busy_o
	,output logic      done_o
);

	map_word_t   sm_mem [`IFM_MAP_DEPTH];

	scan_state_e state_r;
	word_idx_t   word_idx_r;
	word_idx_t   last_idx_r;
	map_word_t   orig_word_r;
	// Bits of the current word not yet issued
	map_word_t   work_word_r;
	credit_t     credit_r;
	logic        done_r;

	map_pos_t    enc_pos_w;
	logic        emit_w;
	logic        empty_w;
	logic        last_bit_w;

	always_ff @(posedge clk_i) begin
		if (sm_wr_en_i) begin
			sm_mem[sm_wr_addr_i] <= sm_wr_data_i;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Chunk walker
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_r    <= SCAN_IDLE;
			word_idx_r <= '0;
			last_idx_r <= '0;
		end else begin
			case (state_r)
				SCAN_IDLE: begin
					if (start_i) begin
						word_idx_r <= '0;
						last_idx_r <= word_count_i;
						state_r    <= SCAN_FETCH;
					end
				end
				SCAN_FETCH: begin
					state_r <= SCAN_EMIT;
				end
				SCAN_EMIT: begin
					// Stays here while credits are exhausted
					if (word_end_o && (word_idx_r == last_idx_r)) begin
						state_r <= SCAN_DONE;
					end else if (word_end_o) begin
						word_idx_r <= word_idx_r + word_idx_t'(1);
						state_r    <= SCAN_FETCH;
					end
				end
				SCAN_DONE: begin
					state_r <= SCAN_IDLE;
				end
				default: begin
					state_r <= SCAN_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state_r == SCAN_FETCH) begin
			orig_word_r <= sm_mem[word_idx_r];
			work_word_r <= sm_mem[word_idx_r];
		end else if (issue_o) begin
			// Drop the lowest set bit
			work_word_r <= work_word_r & (work_word_r - map_word_t'(1));
		end
	end

	// Priority encoder, lowest set bit wins
	always_comb begin
		enc_pos_w = '0;
		for (int i = `IFM_MAP_W - 1; i >= 0; i--) begin
			if (work_word_r[i]) begin
				enc_pos_w = map_pos_t'(i);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Credits and completion
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			credit_r <= credit_t'(`IFM_CREDITS);
		end else if (issue_o && !credit_i) begin
			credit_r <= credit_r - credit_t'(1);
		end else if (credit_i && !issue_o) begin
			credit_r <= credit_r + credit_t'(1);
		end
	end

	// One cycle behind SCAN_DONE, so it lands after the last beat
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			done_r <= 1'b0;
		end else begin
			done_r <= (state_r == SCAN_DONE);
		end
	end

	assign emit_w     = (state_r == SCAN_EMIT);
	assign empty_w    = (work_word_r == '0);
	assign last_bit_w = ((work_word_r & (work_word_r - map_word_t'(1))) == '0);

	assign issue_o       = emit_w && !empty_w && (credit_r != '0);
	assign word_end_o    = (emit_w && empty_w) || (issue_o && last_bit_w);
	assign chunk_start_o = (state_r == SCAN_IDLE) && start_i;

	assign map_word_o  = orig_word_r;
	assign match_pos_o = enc_pos_w;
	assign chan_idx_o  = {word_idx_r, enc_pos_w};

	assign busy_o = (state_r != SCAN_IDLE);
	assign done_o = done_r;

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the IFM chunk testbench with Verilator

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=ifm_chunk_sim

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f tb.f --top-module ifm_chunk_tb \
	--Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed, see $LOG"
exit 1

// File: sim/ifm_chunk_checker.sv
`timescale 1ns/1ns
`include "ifm_consts.svh"

module ifm_chunk_checker (
	 input logic clk_i
	,input logic rst_i
	,input logic issue_i
	,input logic credit_i
	,input logic out_valid_i
	,input logic done_i
	,input logic busy_i
);

	// Beats issued and not yet paid back by the consumer
	int unsigned outstanding_r;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			outstanding_r <= 0;
		end else if (issue_i && !credit_i) begin
			outstanding_r <= outstanding_r + 1;
		end else if (credit_i && !issue_i) begin
			outstanding_r <= outstanding_r - 1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output protocol
	//////////////////////////////////////////////////////////////////////

	// Only the beat right after the last issue may trail the busy window
	valid_while_idle: assert property (@(posedge clk_i) disable iff (rst_i)
		(!busy_i && !$past(busy_i)) |-> !out_valid_i)
		else $error("out_valid_o high while idle and not right after the last issue");

	credit_bound: assert property (@(posedge clk_i) disable iff (rst_i)
		outstanding_r <= `IFM_CREDITS)
		else $error("more beats outstanding than credits granted");

	done_single: assert property (@(posedge clk_i) disable iff (rst_i)
		done_i |=> !done_i)
		else $error("done_o held longer than one cycle");

	quiet_after_reset: assert property (@(posedge clk_i)
		$fell(rst_i) |-> (!out_valid_i && !done_i && !busy_i))
		else $error("outputs not low right after reset");

endmodule

bind ifm_chunk_top ifm_chunk_checker u_checker (
	 .clk_i       (clk_i)
	,.rst_i       (rst_i)
	,.issue_i     (issue_w)
	,.credit_i    (credit_i)
	,.out_valid_i (out_valid_o)
	,.done_i      (done_o)
	,.busy_i      (busy_o)
);

// File: sim/ifm_chunk_tb.sv
`timescale 1ns/1ns
`include "ifm_consts.svh"

module ifm_chunk_tb import ifm_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 2000;
	localparam int CREDIT_DELAY   = 3;

	logic      clk;
	logic      rst;
	logic      sm_wr_en;
	word_idx_t sm_wr_addr;
	map_word_t sm_wr_data;
	logic      nz_wr_en;
	mem_addr_t nz_wr_addr;
	data_t     nz_wr_data;
	logic      start;
	word_idx_t word_count;
	logic      credit;
	logic      out_valid;
	chan_idx_t out_index;
	data_t     out_data;
	logic      done;
	logic      busy;

	map_word_t map_words [`IFM_MAP_DEPTH];
	chan_idx_t exp_index [$];
	data_t     exp_data [$];
	// Cycle at which each beat's credit goes back
	int        due_cycle [$];

	int     num_words = 0;
	int     exp_total = 0;
	int     chunk_tag = 0;
	int     cyc = 0;
	int     errors = 0;
	int     checks = 0;
	int     beats = 0;
	int     pause_beats = 0;
	int     done_count = 0;
	bit     paused = 1'b0;
	integer seed = 32'hbd0a;

	tb_clock #(.PERIOD_NS(40)) tb_clk (.clk_o(clk));

	ifm_chunk_top DUT (
		 .clk_i        (clk)
		,.rst_i        (rst)
		,.sm_wr_en_i   (sm_wr_en)
		,.sm_wr_addr_i (sm_wr_addr)
		,.sm_wr_data_i (sm_wr_data)
		,.nz_wr_en_i   (nz_wr_en)
		,.nz_wr_addr_i (nz_wr_addr)
		,.nz_wr_data_i (nz_wr_data)
		,.start_i      (start)
		,.word_count_i (word_count)
		,.credit_i     (credit)
		,.out_valid_o  (out_valid)
		,.out_index_o  (out_index)
		,.out_data_o   (out_data)
		,.done_o       (done)
		,.busy_o       (busy)
	);

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Packed entry k of a chunk, odd multiplier keeps every entry distinct
	function automatic data_t value_at(int tag, int k);
		return data_t'((tag * 32'h1111) ^ ((k * 32'h0b57) + 32'h0031));
	endfunction

	function automatic int count_ones(int n);
		int ones;
		ones = 0;
		for (int w = 0; w < n; w++) begin
			for (int b = 0; b < `IFM_MAP_W; b++) begin
				if (map_words[w][b]) begin
					ones++;
				end
			end
		end
		return ones;
	endfunction

	// Set bits in channel order, value k taken from packed entry k
	task automatic build_expected();
		int k;
		k = 0;
		exp_index.delete();
		exp_data.delete();
		for (int w = 0; w < num_words; w++) begin
			for (int b = 0; b < `IFM_MAP_W; b++) begin
				if (map_words[w][b]) begin
					exp_index.push_back(chan_idx_t'(w * `IFM_MAP_W + b));
					exp_data.push_back(value_at(chunk_tag, k));
					k++;
				end
			end
		end
		exp_total = k;
	endtask

	task automatic check_equal(string what, int expected, int seen);
		checks++;
		if (expected != seen) begin
			errors++;
			$display("FAIL t=%0t: %s expected %0d, seen %0d", $time, what, expected, seen);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Host side
	//////////////////////////////////////////////////////////////////////

	task automatic load_chunk(int n);
		int ones;
		num_words = n;
		chunk_tag++;
		ones = count_ones(n);
		for (int w = 0; w < n; w++) begin
			@(posedge clk);
			sm_wr_en   <= 1'b1;
			sm_wr_addr <= word_idx_t'(w);
			sm_wr_data <= map_words[w];
		end
		@(posedge clk);
		sm_wr_en <= 1'b0;
		for (int e = 0; e < ones; e++) begin
			nz_wr_en   <= 1'b1;
			nz_wr_addr <= mem_addr_t'(e);
			nz_wr_data <= value_at(chunk_tag, e);
			@(posedge clk);
		end
		nz_wr_en <= 1'b0;
		build_expected();
	endtask

	task automatic start_chunk();
		while (busy) begin
			@(posedge clk);
		end
		beats      = 0;
		done_count = 0;
		@(posedge clk);
		start      <= 1'b1;
		word_count <= word_idx_t'(num_words - 1);
		@(posedge clk);
		start <= 1'b0;
		// Scanner leaves idle on the start pulse
		@(negedge clk);
		check_equal("busy after start", 1, busy);
	endtask

	task automatic wait_done();
		while (done_count == 0) begin
			@(posedge clk);
		end
		@(negedge clk);
		check_equal("busy after done", 0, busy);
		check_equal("beat count", exp_total, beats);
		if (exp_index.size() != 0) begin
			errors++;
			$display("Chunk ended with %0d expected beats never seen", exp_index.size());
		end
		repeat (2) @(posedge clk);
		check_equal("done pulses", 1, done_count);
	endtask

	task automatic run_chunk(int n);
		load_chunk(n);
		start_chunk();
		wait_done();
	endtask

	// All credits back with the DUT before a stall test
	task automatic drain_credits();
		while (due_cycle.size() != 0) begin
			@(negedge clk);
		end
		repeat (2) @(posedge clk);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	task automatic dense_map();
		for (int w = 0; w < `IFM_MAP_DEPTH; w++) begin
			map_words[w] = 8'hff;
		end
		run_chunk(`IFM_MAP_DEPTH);
	endtask

	task automatic mixed_map();
		map_words[0] = 8'h00;
		map_words[1] = 8'h01;
		map_words[2] = 8'h80;
		map_words[3] = 8'h00;
		map_words[4] = 8'h5a;
		map_words[5] = 8'h10;
		map_words[6] = 8'h00;
		map_words[7] = 8'h81;
		run_chunk(8);
	endtask

	task automatic credit_stall();
		for (int w = 0; w < 4; w++) begin
			map_words[w] = 8'hff;
		end
		load_chunk(4);
		drain_credits();
		@(negedge clk);
		paused      = 1'b1;
		pause_beats = 0;
		start_chunk();
		repeat (30) @(posedge clk);
		@(negedge clk);
		paused = 1'b0;
		// Only the granted credits can go out while the consumer holds
		check_equal("beats during stall", `IFM_CREDITS, pause_beats);
		wait_done();
	endtask

	task automatic chunk_restart();
		map_words[0] = 8'hf0;
		map_words[1] = 8'h0f;
		map_words[2] = 8'h33;
		run_chunk(3);
	endtask

	task automatic random_maps();
		int n;
		for (int c = 0; c < 3; c++) begin
			n = ($random(seed) & 7) + 1;
			for (int w = 0; w < n; w++) begin
				map_words[w] = map_word_t'($random(seed));
			end
			run_chunk(n);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Consumer, cycle count and timeout
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		cyc++;
		if (cyc >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("ERRORS FOUND");
			$finish;
		end else if (rst) begin
			credit <= 1'b0;
			due_cycle.delete();
		end else if (!paused && due_cycle.size() > 0 && due_cycle[0] <= cyc) begin
			due_cycle.delete(0);
			credit <= 1'b1;
		end else begin
			credit <= 1'b0;
		end
	end

	// Outputs sampled away from the driving edge
	always @(negedge clk) begin
		if (!rst && out_valid) begin
			beats++;
			if (paused) begin
				pause_beats++;
			end
			due_cycle.push_back(cyc + CREDIT_DELAY);
			if (exp_index.size() == 0) begin
				errors++;
				$display("Unexpected output beat at %0t with index %0d", $time, out_index);
			end else begin
				check_equal("channel index", exp_index.pop_front(), out_index);
				check_equal("value", exp_data.pop_front(), out_data);
			end
		end
		if (!rst && done) begin
			done_count++;
			if (exp_index.size() != 0) begin
				errors++;
				$display("done_o rose at %0t before all beats came out", $time);
			end
		end
	end

	initial begin
		rst        = 1'b1;
		sm_wr_en   = 1'b0;
		sm_wr_addr = '0;
		sm_wr_data = '0;
		nz_wr_en   = 1'b0;
		nz_wr_addr = '0;
		nz_wr_data = '0;
		start      = 1'b0;
		word_count = '0;
		credit     = 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		dense_map();
		mixed_map();
		credit_stall();
		chunk_restart();
		random_maps();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD_NS = 40
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk_o = ~clk_o;
		end
	end

endmodule

// File: tb.f
+incdir+hw
hw/ifm_pkg.sv
hw/prefix_sum.sv
hw/ifm_input_sel.sv
hw/sparsemap_scan.sv
hw/ifm_data_mem.sv
hw/ifm_chunk_top.sv
sim/ifm_chunk_checker.sv
sim/tb_clock.sv
sim/ifm_chunk_tb.sv
